/* files.f */
design/uart_pkg.sv
design/uart_regs.sv
design/uart_tx.sv
design/uart_rx.sv
design/uart_top.sv
testbench/uart_tb.sv

/* Bender.yml */
package:
  name: uart

sources:
  - files:
      - design/uart_pkg.sv
      - design/uart_regs.sv
      - design/uart_tx.sv
      - design/uart_rx.sv
      - design/uart_top.sv
  - target: test
    files:
      - testbench/uart_tb.sv

/* testbench/uart_tb.sv */
`timescale 1ns/10ps

module uart_tb;
    import uart_pkg::*;

    localparam int CLK_HALF    = 4;     // 8 ns period
    localparam int N_FRAMES    = 30;    // Frames sent plus idle waits of frame length
    localparam int MAX_CPB     = 20;    // Largest divider used
    localparam int WATCHDOG_NS = N_FRAMES * 12 * MAX_CPB * 8 * 2;
    localparam int POLL_MAX    = 500;   // STAT reads before giving up

    logic      clk;
    logic      rst;
    bus_req_t  bus;
    bus_data_t rdata;
    logic      irq;
    logic      txd;
    logic      rxd_drv;    // Serial line driven by the testbench
    logic      loop_en;    // Feed txd back into rxd
    logic      rxd_line;

    assign rxd_line = loop_en ? txd : rxd_drv;

    uart_top #(
        .CPB_RESET (16'd434)
    ) dut0 (
        .clk   (clk),
        .rst   (rst),
        .bus   (bus),
        .rdata (rdata),
        .irq   (irq),
        .txd   (txd),
        .rxd   (rxd_line)
    );

    initial clk = 1'b0;
    always #CLK_HALF clk = ~clk;

    initial begin
        #(WATCHDOG_NS);
        abort_run("Watchdog expired, the run took far longer than its frames need");
    end

    ////////////////////////////////////////////////////////////
    // Checking and bus access
    ////////////////////////////////////////////////////////////
    task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            $display("ERR %0t %s got %0h expected %0h", $time, name, got, exp);
            $display("CHECKS FAILED");
            $fatal(1);
        end
    endtask

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("CHECKS FAILED");
        $fatal(1);
    endtask

    task automatic bus_write(input reg_addr_t addr, input bus_data_t data);
        @(negedge clk);
        bus.wr    = 1'b1;
        bus.addr  = addr;
        bus.wdata = data;
        @(negedge clk);
        bus.wr    = 1'b0;
    endtask

    task automatic bus_read(input reg_addr_t addr, output bus_data_t data);
        @(negedge clk);
        bus.rd   = 1'b1;
        bus.addr = addr;
        @(negedge clk);
        bus.rd   = 1'b0;
        data     = rdata;  // Valid the cycle after rd
    endtask

    // Poll STAT until one bit is set and hand back that word
    task automatic wait_flag(input int bit_pos, input string what, output bus_data_t stat);
        int polls;
        polls = 0;
        bus_read(ADDR_STAT, stat);
        while (!stat[bit_pos]) begin
            polls++;
            if (polls > POLL_MAX) abort_run({"Timed out waiting for ", what});
            bus_read(ADDR_STAT, stat);
        end
    endtask

    task automatic wait_irq(input int max_cycles);
        int n;
        n = 0;
        while (!irq) begin
            @(negedge clk);
            n++;
            if (n > max_cycles) abort_run("irq never rose");
        end
    endtask

    ////////////////////////////////////////////////////////////
    // Serial line
    ////////////////////////////////////////////////////////////
    task automatic send_frame(input byte_t data, input logic stop_lvl, input int cpb);
        @(negedge clk);
        rxd_drv = 1'b0;  // Start bit
        repeat (cpb) @(negedge clk);
        for (int i = 0; i < 8; i++) begin
            rxd_drv = data[i];  // LSB first
            repeat (cpb) @(negedge clk);
        end
        rxd_drv = stop_lvl;
        repeat (cpb) @(negedge clk);
        rxd_drv = 1'b1;
    endtask

    task automatic expect_frame(input byte_t data, input logic stop_two, input int cpb);
        int        waited;
        bus_data_t stat;
        waited = 0;
        @(negedge clk);
        while (txd) begin
            waited++;
            if (waited > 4 * cpb) abort_run("No start bit seen on txd");
            @(negedge clk);
        end
        // Step from just past the start edge to mid start bit
        repeat (cpb / 2) @(negedge clk);
        check("txd start", txd, 1'b0);
        for (int i = 0; i < 8; i++) begin
            repeat (cpb) @(negedge clk);
            check($sformatf("txd data[%0d]", i), txd, data[i]);
        end
        repeat (cpb) @(negedge clk);
        check("txd stop", txd, 1'b1);
        if (stop_two) begin
            repeat (cpb) @(negedge clk);
            check("txd stop2", txd, 1'b1);
            bus_read(ADDR_STAT, stat);  // Still inside second stop bit
            check("stat tx_busy in stop2", stat[STAT_TX_BUSY], 1'b1);
        end
    endtask

    ////////////////////////////////////////////////////////////
    // Directed tests
    ////////////////////////////////////////////////////////////
    task automatic reset_values();
        bus_data_t d;
        bus_read(ADDR_CPB, d);
        check("CPB", d, 16'd434);
        bus_read(ADDR_CFG, d);
        check("CFG", d, 16'd0);
        bus_read(ADDR_STAT, d);
        check("STAT", d, 16'd0);
        check("txd", txd, 1'b1);
        check("irq", irq, 1'b0);
    endtask

    task automatic transmit_frames();
        byte_t     b;
        byte_t     b2;
        bus_data_t d;
        bus_write(ADDR_CPB, 16'd8);
        for (int n = 0; n < 4; n++) begin
            b = byte_t'($urandom_range(255, 0));
            bus_write(ADDR_TXD, {8'd0, b});
            check("txd idle after write", txd, 1'b1);  // Falls one edge later
            expect_frame(b, 1'b0, 8);
            wait_flag(STAT_TX_DONE, "tx_done", d);
            check("stat tx_busy", d[STAT_TX_BUSY], 1'b0);
            bus_read(ADDR_STAT, d);
            check("stat tx_done cleared", d[STAT_TX_DONE], 1'b0);
        end
        // Two stop bits
        bus_write(ADDR_CFG, 16'h0001);
        b = byte_t'($urandom_range(255, 0));
        bus_write(ADDR_TXD, {8'd0, b});
        expect_frame(b, 1'b1, 8);
        wait_flag(STAT_TX_DONE, "tx_done after two stop bits", d);
        check("stat tx_busy after stop2", d[STAT_TX_BUSY], 1'b0);
        bus_write(ADDR_CFG, 16'h0000);
        // Second write lands mid frame and is dropped
        b  = byte_t'($urandom_range(255, 0));
        b2 = ~b;
        bus_write(ADDR_TXD, {8'd0, b});
        fork
            expect_frame(b, 1'b0, 8);
            begin
                repeat (20) @(negedge clk);
                bus_write(ADDR_TXD, {8'd0, b2});
            end
        join
        wait_flag(STAT_TX_DONE, "tx_done of busy frame", d);
        repeat (3 * 8) begin
            @(negedge clk);
            check("txd idle after dropped write", txd, 1'b1);
        end
    endtask

    task automatic receive_frames();
        byte_t     b;
        bus_data_t d;
        int        cpb;
        cpb = 8;
        for (int pass = 0; pass < 2; pass++) begin
            bus_write(ADDR_CPB, cpb[15:0]);
            for (int n = 0; n < 4; n++) begin
                b = byte_t'($urandom_range(255, 0));
                send_frame(b, 1'b1, cpb);
                wait_flag(STAT_RX_VALID, "rx_valid", d);
                check("stat frame_err", d[STAT_FRAME_ERR], 1'b0);
                bus_read(ADDR_RXD, d);
                check("rxd data", d, {8'd0, b});
                bus_read(ADDR_STAT, d);
                check("stat rx_valid cleared", d[STAT_RX_VALID], 1'b0);
            end
            cpb = $urandom_range(20, 6);  // Odd dividers too
        end
        bus_write(ADDR_CPB, 16'd8);
    endtask

    task automatic error_cases();
        byte_t     b1;
        byte_t     b2;
        bus_data_t d;
        b1 = byte_t'($urandom_range(255, 0));
        b2 = b1 ^ 8'h5A;
        send_frame(b1, 1'b1, 8);
        send_frame(b2, 1'b1, 8);
        wait_flag(STAT_RX_OVERRUN, "rx_overrun", d);
        check("stat rx_valid with overrun", d[STAT_RX_VALID], 1'b1);
        bus_read(ADDR_RXD, d);
        check("rxd after overrun", d, {8'd0, b1});
        // Low stop bit
        send_frame(b2, 1'b0, 8);
        wait_flag(STAT_FRAME_ERR, "frame_err", d);
        check("stat rx_valid on frame_err", d[STAT_RX_VALID], 1'b0);
        repeat (8) @(negedge clk);
        // Two-cycle glitch stays under half a bit
        @(negedge clk);
        rxd_drv = 1'b0;
        repeat (2) @(negedge clk);
        rxd_drv = 1'b1;
        repeat (12 * 8) @(negedge clk);
        bus_read(ADDR_STAT, d);
        check("stat rx bits after glitch",
              {d[STAT_FRAME_ERR], d[STAT_RX_OVERRUN], d[STAT_RX_VALID]}, 3'b000);
    endtask

    task automatic interrupt_lines();
        byte_t     b;
        bus_data_t d;
        bus_write(ADDR_CFG, 16'h0002);  // irq_rx_en
        check("irq before rx", irq, 1'b0);
        b = byte_t'($urandom_range(255, 0));
        send_frame(b, 1'b1, 8);
        wait_irq(20 * 8);
        bus_read(ADDR_RXD, d);
        check("rxd with irq", d, {8'd0, b});
        check("irq after RXD read", irq, 1'b0);
        bus_write(ADDR_CFG, 16'h0004);  // irq_tx_en
        b = byte_t'($urandom_range(255, 0));
        bus_write(ADDR_TXD, {8'd0, b});
        expect_frame(b, 1'b0, 8);
        wait_irq(4 * 8);
        bus_read(ADDR_STAT, d);
        check("stat tx_done with irq", d[STAT_TX_DONE], 1'b1);
        check("irq after STAT read", irq, 1'b0);
        bus_write(ADDR_CFG, 16'h0000);
    endtask

    task automatic loopback_path();
        byte_t     b;
        bus_data_t d;
        loop_en = 1'b1;  // Both lines idle high so no edge
        for (int n = 0; n < 4; n++) begin
            b = byte_t'($urandom_range(255, 0));
            bus_write(ADDR_TXD, {8'd0, b});
            // Receiver reports before the stop bit ends
            wait_flag(STAT_TX_DONE, "loopback tx_done", d);
            check("loopback rx_valid", d[STAT_RX_VALID], 1'b1);
            bus_read(ADDR_RXD, d);
            check("loopback data", d, {8'd0, b});
        end
        loop_en = 1'b0;
    endtask

    ////////////////////////////////////////////////////////////
    // Main sequence
    ////////////////////////////////////////////////////////////
    initial begin
        void'($urandom(34));  // One fixed seed for the run
        bus     = '0;
        rst     = 1'b1;
        rxd_drv = 1'b1;
        loop_en = 1'b0;
        repeat (8) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;

        reset_values();
        transmit_frames();
        receive_frames();
        error_cases();
        interrupt_lines();
        loopback_path();

        $display("ALL CHECKS PASSED");
        $finish;
    end

endmodule

/* design/uart_top.sv */
`timescale 1ns/10ps

module uart_top #(
    parameter uart_pkg::cpb_t CPB_RESET = 16'd434
) (
    input  logic                 clk,
    input  logic                 rst,
    input  uart_pkg::bus_req_t   bus,
    output uart_pkg::bus_data_t  rdata,
    output logic                 irq,
    output logic                 txd,
    input  logic                 rxd
);
    import uart_pkg::*;

    line_cfg_t line_cfg;  // Shared by both serial units
    tx_req_t   tx_req;
    logic      tx_busy;
    logic      tx_done;
    rx_evt_t   rx_evt;

    ////////////////////////////////////////////////////////////
    // Register block
    ////////////////////////////////////////////////////////////
    uart_regs #(
        .CPB_RESET (CPB_RESET)
    ) regs0 (
        .clk      (clk),
        .rst      (rst),
        .bus      (bus),
        .rdata    (rdata),
        .line_cfg (line_cfg),
        .tx_req   (tx_req),
        .tx_busy  (tx_busy),
        .tx_done  (tx_done),
        .rx_evt   (rx_evt),
        .irq      (irq)
    );

    ////////////////////////////////////////////////////////////
    // Serial units, each with its own bit timer
    ////////////////////////////////////////////////////////////
    uart_tx tx0 (
        .clk      (clk),
        .rst      (rst),
        .line_cfg (line_cfg),
        .tx_req   (tx_req),
        .txd      (txd),
        .tx_busy  (tx_busy),
        .tx_done  (tx_done)
    );

    uart_rx rx0 (
        .clk      (clk),
        .rst      (rst),
        .line_cfg (line_cfg),
        .rxd      (rxd),      // Async, synchronized inside
        .rx_evt   (rx_evt)
    );

endmodule

/* design/uart_rx.sv */
`timescale 1ns/10ps

module uart_rx (
    input  logic                 clk,
    input  logic                 rst,
    input  uart_pkg::line_cfg_t  line_cfg,
    input  logic                 rxd,
    output uart_pkg::rx_evt_t    rx_evt
);
    import uart_pkg::*;

    logic       rxd_meta;   // First sync stage
    logic       rxd_sync;   // Safe to use
    logic       rxd_prev;   // For edge detect
    logic       start_edge;

    rx_state_t  state;
    cpb_t       bit_tmr;
    logic [2:0] bit_idx;
    byte_t      shreg;
    logic       half_end;
    logic       full_end;

    logic       evt_valid;
    byte_t      evt_data;
    logic       evt_ferr;

    ////////////////////////////////////////////////////////////
    // Input synchronizer
    ////////////////////////////////////////////////////////////
    always_ff @(posedge clk) begin
        if (rst) begin
            rxd_meta <= 1'b1;
            rxd_sync <= 1'b1;
            rxd_prev <= 1'b1;
        end else begin
            rxd_meta <= rxd;
            rxd_sync <= rxd_meta;
            rxd_prev <= rxd_sync;
        end
    end

    assign start_edge = rxd_prev && !rxd_sync;  // Falling edge
    assign half_end   = (bit_tmr == (line_cfg.cpb >> 1) - 16'd1);
    assign full_end   = (bit_tmr == line_cfg.cpb - 16'd1);

    ////////////////////////////////////////////////////////////
    // Sampling FSM
    ////////////////////////////////////////////////////////////
    always_ff @(posedge clk) begin
        if (rst) begin
            state     <= RX_IDLE;
            bit_tmr   <= '0;
            bit_idx   <= '0;
            evt_valid <= 1'b0;
        end else begin
            evt_valid <= 1'b0;
            case (state)
                RX_IDLE: begin
                    bit_tmr <= '0;  // Phase re-aligns on each edge
                    if (start_edge) state <= RX_START;
                end
                RX_START: begin
                    if (half_end) begin
                        bit_tmr <= '0;
                        bit_idx <= '0;
                        // High at mid start bit is a glitch
                        state   <= rxd_sync ? RX_IDLE : RX_DATA;
                    end else begin
                        bit_tmr <= bit_tmr + 16'd1;
                    end
                end
                RX_DATA: begin
                    if (full_end) begin
                        bit_tmr <= '0;
                        bit_idx <= bit_idx + 3'd1;
                        if (bit_idx == 3'd7) state <= RX_STOP;
                    end else begin
                        bit_tmr <= bit_tmr + 16'd1;
                    end
                end
                RX_STOP: begin
                    if (full_end) begin
                        bit_tmr   <= '0;
                        evt_valid <= 1'b1;  // Reported at first stop sample
                        state     <= RX_IDLE;
                    end else begin
                        bit_tmr <= bit_tmr + 16'd1;
                    end
                end
                default: state <= RX_IDLE;
            endcase
        end
    end

    // Data path, LSB arrives first
    always_ff @(posedge clk) begin
        if (state == RX_DATA && full_end) shreg <= {rxd_sync, shreg[7:1]};
        if (state == RX_STOP && full_end) begin
            evt_data <= shreg;
            evt_ferr <= !rxd_sync;  // Stop must be high
        end
    end

    assign rx_evt = '{valid: evt_valid, data: evt_data, frame_err: evt_ferr};

    a_valid_pulse: assert property (@(posedge clk) disable iff (rst)
        rx_evt.valid |=> !rx_evt.valid)
        else $error("rx valid longer than one cycle");

endmodule

/* design/uart_tx.sv */
`timescale 1ns/10ps

module uart_tx (
    input  logic                 clk,
    input  logic                 rst,
    input  uart_pkg::line_cfg_t  line_cfg,
    input  uart_pkg::tx_req_t    tx_req,
    output logic                 txd,
    output logic                 tx_busy,
    output logic                 tx_done
);
    import uart_pkg::*;

    tx_state_t  state;
    cpb_t       bit_tmr;   // Cycles into current bit
    logic [2:0] bit_idx;   // Data bit being sent
    logic       stop_cnt;  // Second stop bit in progress
    byte_t      shreg;
    logic       bit_end;

    assign bit_end = (bit_tmr == line_cfg.cpb - 16'd1);  // Last cycle of a bit
    assign tx_busy = (state != TX_IDLE);

    ////////////////////////////////////////////////////////////
    // Frame FSM and bit timer
    ////////////////////////////////////////////////////////////
    always_ff @(posedge clk) begin
        if (rst) begin
            state    <= TX_IDLE;
            txd      <= 1'b1;  // Line idles high
            tx_done  <= 1'b0;
            bit_tmr  <= '0;
            bit_idx  <= '0;
            stop_cnt <= 1'b0;
        end else begin
            tx_done <= 1'b0;
            // Timer restarts at every bit boundary
            if (state == TX_IDLE || bit_end) bit_tmr <= '0;
            else                            bit_tmr <= bit_tmr + 16'd1;

            case (state)
                TX_IDLE: begin
                    txd <= 1'b1;
                    if (tx_req.start) begin
                        state <= TX_START;
                        txd   <= 1'b0;  // Start bit
                    end
                end
                TX_START: begin
                    if (bit_end) begin
                        state   <= TX_DATA;
                        txd     <= shreg[0];  // Bit 0 first
                        bit_idx <= '0;
                    end
                end
                TX_DATA: begin
                    if (bit_end) begin
                        if (bit_idx == 3'd7) begin
                            state    <= TX_STOP;
                            txd      <= 1'b1;
                            stop_cnt <= 1'b0;
                        end else begin
                            txd     <= shreg[0];
                            bit_idx <= bit_idx + 3'd1;
                        end
                    end
                end
                TX_STOP: begin
                    if (bit_end) begin
                        if (line_cfg.stop_two && !stop_cnt) begin
                            stop_cnt <= 1'b1;  // One more bit time high
                        end else begin
                            state   <= TX_IDLE;
                            tx_done <= 1'b1;   // Same edge busy falls
                        end
                    end
                end
                default: state <= TX_IDLE;
            endcase
        end
    end

    // Shift register, LSB out first
    always_ff @(posedge clk) begin
        if (state == TX_IDLE && tx_req.start) begin
            shreg <= tx_req.data;
        end else if (bit_end && (state == TX_START || state == TX_DATA)) begin
            shreg <= {1'b1, shreg[7:1]};
        end
    end

    // Register block must hold off while a frame is in flight
    a_no_start_busy: assert property (@(posedge clk) disable iff (rst)
        tx_req.start |-> !tx_busy)
        else $error("tx start while busy");

endmodule

/* design/uart_regs.sv */
`timescale 1ns/10ps

module uart_regs #(
    parameter uart_pkg::cpb_t CPB_RESET = 16'd434
) (
    input  logic                 clk,
    input  logic                 rst,
    input  uart_pkg::bus_req_t   bus,
    output uart_pkg::bus_data_t  rdata,
    output uart_pkg::line_cfg_t  line_cfg,
    output uart_pkg::tx_req_t    tx_req,
    input  logic                 tx_busy,
    input  logic                 tx_done,
    input  uart_pkg::rx_evt_t    rx_evt,
    output logic                 irq
);
    import uart_pkg::*;

    // Config registers
    cpb_t  cpb_q;
    logic  stop_two_q;
    logic  irq_rx_en_q;
    logic  irq_tx_en_q;

    // Transmit request
    logic  tx_start_q;
    byte_t tx_data_q;

    // Sticky flags and stored byte
    logic  done_f;
    logic  rxv_f;
    logic  ovr_f;
    logic  ferr_f;
    byte_t rx_byte;

    bus_data_t stat_word;
    logic      rd_rxd;
    logic      rd_stat;
    logic      tx_accept;
    logic      rx_good;

    assign rd_rxd    = bus.rd && (bus.addr == ADDR_RXD);
    assign rd_stat   = bus.rd && (bus.addr == ADDR_STAT);
    assign tx_accept = bus.wr && (bus.addr == ADDR_TXD) && !tx_busy && !tx_start_q; // Busy drops it
    assign rx_good   = rx_evt.valid && !rx_evt.frame_err;

    ////////////////////////////////////////////////////////////
    // Bus writes and status flags
    ////////////////////////////////////////////////////////////
    always_ff @(posedge clk) begin
        if (rst) begin
            cpb_q       <= CPB_RESET;
            stop_two_q  <= 1'b0;
            irq_rx_en_q <= 1'b0;
            irq_tx_en_q <= 1'b0;
            tx_start_q  <= 1'b0;
            done_f      <= 1'b0;
            rxv_f       <= 1'b0;
            ovr_f       <= 1'b0;
            ferr_f      <= 1'b0;
        end else begin
            tx_start_q <= tx_accept;  // Single pulse, blocked by itself
            if (bus.wr && bus.addr == ADDR_CPB) cpb_q <= bus.wdata;
            if (bus.wr && bus.addr == ADDR_CFG) begin
                stop_two_q  <= bus.wdata[CFG_STOP_TWO];
                irq_rx_en_q <= bus.wdata[CFG_IRQ_RX_EN];
                irq_tx_en_q <= bus.wdata[CFG_IRQ_TX_EN];
            end
            // Clear on read first, new events win below
            if (rd_rxd) rxv_f <= 1'b0;
            if (rd_stat) begin
                done_f <= 1'b0;
                ovr_f  <= 1'b0;
                ferr_f <= 1'b0;
            end
            if (tx_done) done_f <= 1'b1;
            if (rx_evt.valid && rx_evt.frame_err) ferr_f <= 1'b1;   // Bad byte not kept
            if (rx_good) begin
                if (rxv_f && !rd_rxd) ovr_f <= 1'b1;  // Old byte stays
                else                  rxv_f <= 1'b1;
            end
        end
    end

    // Payload capture
    always_ff @(posedge clk) begin
        if (tx_accept) tx_data_q <= bus.wdata[7:0];
        if (rx_good && (!rxv_f || rd_rxd)) rx_byte <= rx_evt.data;
    end

    always_comb begin
        stat_word                  = '0;
        stat_word[STAT_TX_BUSY]    = tx_busy;
        stat_word[STAT_TX_DONE]    = done_f;
        stat_word[STAT_RX_VALID]   = rxv_f;
        stat_word[STAT_RX_OVERRUN] = ovr_f;
        stat_word[STAT_FRAME_ERR]  = ferr_f;
    end

    ////////////////////////////////////////////////////////////
    // Registered read data, held until next read
    ////////////////////////////////////////////////////////////
    always_ff @(posedge clk) begin
        if (rst) begin
            rdata <= '0;
        end else if (bus.rd) begin
            case (bus.addr)
                ADDR_CPB:  rdata <= cpb_q;
                ADDR_CFG:  rdata <= {13'd0, irq_tx_en_q, irq_rx_en_q, stop_two_q};
                ADDR_RXD:  rdata <= {8'd0, rx_byte};
                ADDR_STAT: rdata <= stat_word;
                default:   rdata <= '0;  // TXD reads as zero
            endcase
        end
    end

    assign line_cfg = '{cpb: cpb_q, stop_two: stop_two_q};
    assign tx_req   = '{start: tx_start_q, data: tx_data_q};
    assign irq      = (rxv_f && irq_rx_en_q) || (done_f && irq_tx_en_q);

    a_no_wr_rd: assert property (@(posedge clk) disable iff (rst)
        !(bus.wr && bus.rd))
        else $error("bus wr and rd high together");

    // Below 4 the receiver half-bit timer breaks down
    a_cpb_min: assert property (@(posedge clk) disable iff (rst)
        (bus.wr && bus.addr == ADDR_CPB) |-> (bus.wdata >= 16'd4))
        else $error("CPB written below 4");

endmodule

/* design/uart_pkg.sv */
package uart_pkg;

    ////////////////////////////////////////////////////////////
    // Widths with a meaning
    ////////////////////////////////////////////////////////////
    typedef logic [15:0] cpb_t;       // Clocks per bit
    typedef logic [7:0]  byte_t;      // One character
    typedef logic [15:0] bus_data_t;  // Register bus word
    typedef logic [2:0]  reg_addr_t;  // Register address

    // Register map
    localparam reg_addr_t ADDR_CPB  = 3'd0;  // Divider, r/w
    localparam reg_addr_t ADDR_CFG  = 3'd1;  // Stop bits and irq enables
    localparam reg_addr_t ADDR_TXD  = 3'd2;  // Write starts a frame
    localparam reg_addr_t ADDR_RXD  = 3'd3;  // Read pops the byte
    localparam reg_addr_t ADDR_STAT = 3'd4;  // Status, read only

    // CFG bit positions
    localparam int CFG_STOP_TWO  = 0;
    localparam int CFG_IRQ_RX_EN = 1;
    localparam int CFG_IRQ_TX_EN = 2;

    // STAT bit positions
    localparam int STAT_TX_BUSY    = 0;
    localparam int STAT_TX_DONE    = 1;  // Sticky
    localparam int STAT_RX_VALID   = 2;
    localparam int STAT_RX_OVERRUN = 3;  // Sticky
    localparam int STAT_FRAME_ERR  = 4;  // Sticky

    ////////////////////////////////////////////////////////////
    // Bundles between the blocks
    ////////////////////////////////////////////////////////////
    typedef struct packed {
        logic      wr;     // One-cycle write strobe
        logic      rd;     // One-cycle read strobe
        reg_addr_t addr;
        bus_data_t wdata;
    } bus_req_t;

    typedef struct packed {
        cpb_t cpb;
        logic stop_two;   // 1 = two stop bits
    } line_cfg_t;

    typedef struct packed {
        logic  start;     // Pulse, only while tx idle
        byte_t data;
    } tx_req_t;

    typedef struct packed {
        logic  valid;     // Pulse at stop-bit sample
        byte_t data;
        logic  frame_err; // Stop bit was low
    } rx_evt_t;

    typedef enum logic [1:0] {TX_IDLE, TX_START, TX_DATA, TX_STOP} tx_state_t;
    typedef enum logic [1:0] {RX_IDLE, RX_START, RX_DATA, RX_STOP} rx_state_t;

endpackage
